//--- Makefile
# Verilator build, run, lint and clean for the execute core

VERILATOR  ?= verilator
TOP        ?= tb_execute_core
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Test completed successfully
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides pass or fail
run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
rtl/arm_isa_pkg.sv
rtl/datapath_pkg.sv
rtl/register_file.sv
rtl/operand_shifter.sv
rtl/alu.sv
rtl/execute_core.sv
dv/tb_execute_core.sv

//--- dv/execute_stim.txt
# op am rn rm rd imm12 set_cc wr_en exp_result exp_flags, all in hex
# exp_flags is NZCV as seen on flags two cycles after the operation issues
1 2 0 0 1 123 0 1 00000123 0
1 2 0 0 2 fff 0 1 00000fff 0
1 2 0 0 3 00a 0 1 0000000a 0
1 0 0 0 4 4ff 0 1 ff000000 0
1 0 0 0 5 1c3 0 1 c0000030 0
1 0 0 0 6 0ab 0 1 000000ab 0
1 1 0 1 7 000 0 1 00000123 0
3 1 1 3 8 000 1 1 0000012d 0
1 3 0 6 9 200 0 1 00000ab0 0
1 3 0 4 a 420 0 1 00ff0000 0
1 3 0 4 b 240 0 1 fff00000 0
1 3 0 6 c 260 0 1 b000000a 0
3 0 4 0 d 401 1 1 00000000 6
1 0 0 0 e 47f 0 1 7f000000 6
3 0 e 0 f 47f 1 1 fe000000 9
2 1 3 1 9 000 1 1 fffffee7 a
2 2 2 0 0 fff 1 0 00000000 4
0 1 4 5 3 000 1 1 c0000000 8
1 2 6 0 6 100 1 1 000001ab 0
3 1 1 6 2 000 0 1 000002ce 0
3 3 2 2 7 080 1 1 0000086a 0
1 2 0 0 1 777 0 0 00000777 0
1 1 0 1 5 000 0 1 00000123 0
2 2 0 0 8 001 1 0 ffffffff a
3 2 0 0 0 000 0 0 00000000 a
0 1 f b 0 000 0 0 fe000000 a
1 1 c d 0 000 1 0 b000000a 8
3 1 b 3 0 000 1 0 bff00000 a

//--- dv/tb_execute_core.sv
// Testbench for the execute core, driven and checked from a stimulus file
`timescale 1ns/10ps

module tb_execute_core;

  import datapath_pkg::*;
  import arm_isa_pkg::*;

  localparam int    RESET_CYCLES   = 10;
  localparam int    TIMEOUT_MARGIN = 20; // Covers reset and pipeline drain
  localparam string STIM_FILE      = "dv/execute_stim.txt";

  // One stimulus line, field order matches the file columns
  typedef struct packed {
    alu_op_t    alu_op;
    addr_mode_t am;
    reg_idx_t   rn;
    reg_idx_t   rm;
    reg_idx_t   rd;
    imm12_t     imm12;
    logic       set_cc;
    logic       wr_en;
    word_t      exp_res;
    flags_t     exp_flags;
  } stim_t;

  logic       clk = 1'b0;
  logic       reset;
  logic       op_valid;
  alu_op_t    alu_op;
  addr_mode_t am;
  reg_idx_t   rn;
  reg_idx_t   rm;
  reg_idx_t   rd;
  imm12_t     imm12;
  logic       set_cc;
  logic       wr_en;
  logic       res_valid;
  word_t      res_data;
  reg_idx_t   res_rd;
  flags_t     flags;

  stim_t stim_q[$];
  int    cycle_count = 0;
  int    cycle_limit = TIMEOUT_MARGIN; // Raised once the file is read

  execute_core DUT (
    .clk       (clk),
    .reset     (reset),
    .op_valid  (op_valid),
    .alu_op    (alu_op),
    .am        (am),
    .rn        (rn),
    .rm        (rm),
    .rd        (rd),
    .imm12     (imm12),
    .set_cc    (set_cc),
    .wr_en     (wr_en),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_rd    (res_rd),
    .flags     (flags)
  );

  always #50 clk = ~clk; // 100 ns period

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_word(input string field, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_now($sformatf("[FAIL] %0d ns: %s is %h, expected %h", $time, field, got, exp));
    end
  endtask

  task automatic check_idx(input string field, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      fail_now($sformatf("[FAIL] %0d ns: %s is %h, expected %h", $time, field, got, exp));
    end
  endtask

  task automatic check_flags(input string field, input flags_t got, input flags_t exp);
    if (got !== exp) begin
      fail_now($sformatf("[FAIL] %0d ns: %s NZCV is %b, expected %b", $time, field, got, exp));
    end
  endtask

  task automatic check_bit(input string field, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("[FAIL] %0d ns: %s is %b, expected %b", $time, field, got, exp));
    end
  endtask

  task automatic read_stimulus();
    int         fd;
    int         rc;
    string      line;
    alu_op_t    t_op;
    addr_mode_t t_am;
    reg_idx_t   t_rn;
    reg_idx_t   t_rm;
    reg_idx_t   t_rd;
    imm12_t     t_imm;
    logic       t_set;
    logic       t_wr;
    word_t      t_res;
    logic [3:0] t_flags;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      fail_now("Could not open the stimulus file dv/execute_stim.txt");
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0 && line.getc(0) != "#") begin // Skip column notes
        rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", t_op, t_am, t_rn, t_rm,
                     t_rd, t_imm, t_set, t_wr, t_res, t_flags);
        if (rc == 10) begin
          stim_q.push_back({t_op, t_am, t_rn, t_rm, t_rd, t_imm, t_set, t_wr, t_res,
                            t_flags});
        end else if (rc > 0) begin
          fail_now("A line of the stimulus file does not hold ten fields");
        end
      end
    end
    $fclose(fd);
    if (stim_q.size() == 0) begin
      fail_now("The stimulus file holds no operations");
    end
  endtask

  task automatic drive_op(input stim_t s);
    op_valid = 1'b1;
    alu_op   = s.alu_op;
    am       = s.am;
    rn       = s.rn;
    rm       = s.rm;
    rd       = s.rd;
    imm12    = s.imm12;
    set_cc   = s.set_cc;
    wr_en    = s.wr_en;
  endtask

  task automatic drive_idle();
    op_valid = 1'b0;
    alu_op   = ALU_AND;
    am       = AM_REG;
    rn       = '0;
    rm       = '0;
    rd       = '0;
    imm12    = '0;
    set_cc   = 1'b0;
    wr_en    = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      fail_now($sformatf("Timeout: the run did not end within %0d cycles", cycle_limit));
    end
  end

  initial begin
    int n;
    reset = 1'b1;
    drive_idle();
    read_stimulus();
    n = stim_q.size();
    cycle_limit = n + TIMEOUT_MARGIN;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
    check_bit("res_valid after reset", res_valid, 1'b0);
    check_flags("flags after reset", flags, '0);
    // Result shows one cycle after issue, flags two cycles after
    for (int k = 0; k <= n + 1; k++) begin
      @(posedge clk);
      #1;
      if (k >= 1 && k - 1 < n) begin
        check_bit("res_valid", res_valid, 1'b1);
        check_word("res_data", res_data, stim_q[k-1].exp_res);
        check_idx("res_rd", res_rd, stim_q[k-1].rd);
      end
      if (k >= 2) begin
        check_flags("flags", flags, stim_q[k-2].exp_flags);
      end
      if (k == n + 1) begin
        check_bit("res_valid when idle", res_valid, 1'b0);
      end
      if (k < n) begin
        drive_op(stim_q[k]);
      end else begin
        drive_idle();
      end
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- rtl/alu.sv
// Four-operation ALU with N, Z, C and V flag generation
`timescale 1ns/10ps

module alu (
  input  datapath_pkg::word_t   a,
  input  datapath_pkg::word_t   b,
  input  arm_isa_pkg::alu_op_t  alu_op,
  output datapath_pkg::word_t   result,
  output datapath_pkg::flags_t  flags_out
);

  import datapath_pkg::*;
  import arm_isa_pkg::*;

  logic [WORD_W:0] sum_ext;  // Carry in the top bit
  logic [WORD_W:0] diff_ext; // Top bit set when a < b unsigned

  always_comb begin
    sum_ext  = {1'b0, a} + {1'b0, b};
    diff_ext = {1'b0, a} - {1'b0, b};
  end

  always_comb begin
    result      = '0;
    flags_out.c = 1'b0; // Logic ops leave C and V clear
    flags_out.v = 1'b0;
    case (alu_op)
      ALU_AND: result = a & b;
      ALU_ORR: result = a | b;
      ALU_SUB: begin
        result      = diff_ext[WORD_W-1:0];
        flags_out.c = diff_ext[WORD_W];
        flags_out.v = (a[WORD_W-1] != b[WORD_W-1]) && (result[WORD_W-1] != a[WORD_W-1]);
      end
      ALU_ADD: begin
        result      = sum_ext[WORD_W-1:0];
        flags_out.c = sum_ext[WORD_W];
        flags_out.v = (a[WORD_W-1] == b[WORD_W-1]) && (result[WORD_W-1] != a[WORD_W-1]);
      end
      default: result = '0;
    endcase
    flags_out.n = result[WORD_W-1];
    flags_out.z = ~|result;
    // A difference is zero exactly when the operands are equal
    if (alu_op == ALU_SUB && !$isunknown({a, b})) begin
      a_zero_flag: assert (flags_out.z == (a == b))
        else $error("alu: Z flag disagrees with operand equality on SUB");
    end
  end

endmodule

//--- rtl/arm_isa_pkg.sv
// ALU operation codes, addressing modes, shift types and the immediate field type
package arm_isa_pkg;

  localparam int IMM_W = 12;

  typedef logic [3:0]       alu_op_t;
  typedef logic [1:0]       addr_mode_t;
  typedef logic [1:0]       shift_t;
  typedef logic [IMM_W-1:0] imm12_t;

  // ALU operations, other codes give zero
  localparam alu_op_t ALU_AND = 4'd0;
  localparam alu_op_t ALU_ORR = 4'd1;
  localparam alu_op_t ALU_SUB = 4'd2;
  localparam alu_op_t ALU_ADD = 4'd3;

  // Second operand addressing modes
  localparam addr_mode_t AM_ROT_IMM   = 2'd0; // Rotated 8-bit immediate
  localparam addr_mode_t AM_REG       = 2'd1; // Register as is
  localparam addr_mode_t AM_ZEXT_IMM  = 2'd2; // Zero-extended 12-bit immediate
  localparam addr_mode_t AM_SHIFT_REG = 2'd3; // Register shifted by immediate

  // Shift types in imm12[6:5]
  localparam shift_t SH_LSL = 2'd0;
  localparam shift_t SH_LSR = 2'd1;
  localparam shift_t SH_ASR = 2'd2;
  localparam shift_t SH_ROR = 2'd3;

endpackage

//--- rtl/datapath_pkg.sv
// Datapath widths with the word, register index and condition flag types
package datapath_pkg;

  localparam int WORD_W    = 32;
  localparam int NUM_REGS  = 16;
  localparam int REG_IDX_W = 4;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Condition codes, N in the top bit
  typedef struct packed {
    logic n; // Negative
    logic z; // Zero
    logic c; // Carry, or borrow on SUB
    logic v; // Signed overflow
  } flags_t;

endpackage

//--- rtl/execute_core.sv
// Two-stage execute datapath with forwarding, execute register, flag register and writeback
`timescale 1ns/10ps

module execute_core (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    op_valid,
  input  arm_isa_pkg::alu_op_t    alu_op,
  input  arm_isa_pkg::addr_mode_t am,
  input  datapath_pkg::reg_idx_t  rn,
  input  datapath_pkg::reg_idx_t  rm,
  input  datapath_pkg::reg_idx_t  rd,
  input  arm_isa_pkg::imm12_t     imm12,
  input  logic                    set_cc,
  input  logic                    wr_en,
  output logic                    res_valid,
  output datapath_pkg::word_t     res_data,
  output datapath_pkg::reg_idx_t  res_rd,
  output datapath_pkg::flags_t    flags
);

  import datapath_pkg::*;
  import arm_isa_pkg::*;

  // Register file read data
  word_t    rf_a;
  word_t    rf_b;

  // Forwarded operands
  word_t    fwd_a;
  word_t    fwd_b;
  word_t    shifted_b;

  // Execute stage register
  logic     ex_valid;
  alu_op_t  ex_op;
  reg_idx_t ex_rd;
  logic     ex_wr_en;
  logic     ex_set_cc;
  word_t    ex_a;
  word_t    ex_b;

  word_t    alu_result;
  flags_t   alu_flags;
  logic     ex_writes; // Execute stage will write ex_rd
  flags_t   flag_q;

  assign ex_writes = ex_valid && ex_wr_en;

  register_file u_register_file (
    .clk       (clk),
    .reset     (reset),
    .wr_en     (ex_writes),
    .wr_idx    (ex_rd),
    .wr_data   (alu_result),
    .rd_idx_a  (rn),
    .rd_idx_b  (rm),
    .rd_data_a (rf_a),
    .rd_data_b (rf_b)
  );

  // Bypass the in-flight result so dependent ops issue back to back
  always_comb begin
    fwd_a = (ex_writes && (ex_rd == rn)) ? alu_result : rf_a;
    fwd_b = (ex_writes && (ex_rd == rm)) ? alu_result : rf_b;
  end

  operand_shifter u_operand_shifter (
    .rm_data (fwd_b),
    .imm12   (imm12),
    .am      (am),
    .operand (shifted_b)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= op_valid;
    end
  end

  // Operation fields held only for valid ops
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_op     <= ALU_AND;
      ex_rd     <= '0;
      ex_wr_en  <= 1'b0;
      ex_set_cc <= 1'b0;
      ex_a      <= '0;
      ex_b      <= '0;
    end else if (op_valid) begin
      ex_op     <= alu_op;
      ex_rd     <= rd;
      ex_wr_en  <= wr_en;
      ex_set_cc <= set_cc;
      ex_a      <= fwd_a;
      ex_b      <= shifted_b;
    end
  end

  alu u_alu (
    .a         (ex_a),
    .b         (ex_b),
    .alu_op    (ex_op),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  // Flags load at the same edge as the writeback
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flag_q <= '0;
    end else if (ex_valid && ex_set_cc) begin
      flag_q <= alu_flags;
    end
  end

  assign res_valid = ex_valid;
  assign res_data  = alu_result;
  assign res_rd    = ex_rd;
  assign flags     = flag_q;

  // No result may appear before an op has been captured after reset
  a_no_result_after_reset: assert property (
    @(posedge clk) $fell(reset) |-> !res_valid
  ) else $error("execute_core: res_valid high in first cycle after reset");

endmodule

//--- rtl/operand_shifter.sv
// Second operand generation for the four addressing modes
`timescale 1ns/10ps

module operand_shifter (
  input  datapath_pkg::word_t       rm_data,
  input  arm_isa_pkg::imm12_t       imm12,
  input  arm_isa_pkg::addr_mode_t   am,
  output datapath_pkg::word_t       operand
);

  import datapath_pkg::*;
  import arm_isa_pkg::*;

  word_t               imm_byte;     // imm12[7:0] zero-extended
  logic [4:0]          rot_amt;      // Twice imm12[11:8]
  logic [4:0]          sh_amt;       // imm12[11:7]
  shift_t              sh_type;
  logic [2*WORD_W-1:0] imm_rot_full;
  logic [2*WORD_W-1:0] rm_ror_full;
  word_t               shifted_rm;

  always_comb begin
    imm_byte     = {{(WORD_W-8){1'b0}}, imm12[7:0]};
    rot_amt      = {imm12[11:8], 1'b0};
    sh_amt       = imm12[11:7];
    sh_type      = imm12[6:5];
    // Rotate right as a shift of the doubled word
    imm_rot_full = {imm_byte, imm_byte} >> rot_amt;
    rm_ror_full  = {rm_data, rm_data} >> sh_amt;
  end

  always_comb begin
    case (sh_type)
      SH_LSL:  shifted_rm = rm_data << sh_amt;
      SH_LSR:  shifted_rm = rm_data >> sh_amt;
      SH_ASR:  shifted_rm = word_t'($signed(rm_data) >>> sh_amt); // Sign fills from the left
      SH_ROR:  shifted_rm = rm_ror_full[WORD_W-1:0];
      default: shifted_rm = '0;
    endcase
  end

  always_comb begin
    case (am)
      AM_ROT_IMM:   operand = imm_rot_full[WORD_W-1:0];
      AM_REG:       operand = rm_data;
      AM_ZEXT_IMM:  operand = {{(WORD_W-IMM_W){1'b0}}, imm12};
      AM_SHIFT_REG: operand = shifted_rm;
      default:      operand = '0;
    endcase
  end

endmodule

//--- rtl/register_file.sv
// Sixteen-entry register file with one-hot write decode and two read ports
`timescale 1ns/10ps

module register_file (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wr_en,
  input  datapath_pkg::reg_idx_t wr_idx,
  input  datapath_pkg::word_t    wr_data,
  input  datapath_pkg::reg_idx_t rd_idx_a,
  input  datapath_pkg::reg_idx_t rd_idx_b,
  output datapath_pkg::word_t    rd_data_a,
  output datapath_pkg::word_t    rd_data_b
);

  import datapath_pkg::*;

  logic [NUM_REGS-1:0] wr_sel; // One-hot register enables
  word_t               regs [NUM_REGS];

  // Write index decode
  always_comb begin
    wr_sel = '0;
    if (wr_en) begin
      wr_sel[wr_idx] = 1'b1;
    end
  end

  for (genvar i = 0; i < NUM_REGS; i++) begin : g_reg
    always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
        regs[i] <= '0;
      end else if (wr_sel[i]) begin
        regs[i] <= wr_data;
      end
    end
  end

  // Read muxes, no internal bypass
  always_comb begin
    rd_data_a = regs[rd_idx_a];
    rd_data_b = regs[rd_idx_b];
  end

  // A write with an unknown index would silently corrupt no or several registers
  a_wr_idx_known: assert property (
    @(posedge clk) disable iff (reset)
    wr_en |-> !$isunknown(wr_idx)
  ) else $error("register_file: write enabled with unknown index");

endmodule
